// File: alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

// register and bus data word
`define ALU_WORD_W 32

// physical register tag
`define ALU_TAG_W 6

// reorder buffer index
`define ALU_ROB_W 5

// raw immediate from the instruction
`define ALU_IMM_W 16

// low bits of operand 0 used by sllv / srlv
`define ALU_SHAMT_W 5

////////////////////////////////////////
// bus counts
////////////////////////////////////////

// complete buses watched by the RS
// bus 0 and bus 1 from the ALUs, bus 2 from the LQ
`define ALU_NUM_BUSES 3

`endif

// File: alu_pkg.sv
`default_nettype none

`include "alu_defs.svh"

package alu_pkg;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // twelve ALU ops
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_NOR  = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLLV = 4'd8,
        ALU_SRLV = 4'd9,
        ALU_LUI  = 4'd10,
        ALU_LINK = 4'd11
    } alu_op_t;

    // where EX takes an operand from
    // bus numbers line up with the complete bus index
    typedef enum logic [1:0] {
        BUS_SEL_0   = 2'd0,
        BUS_SEL_1   = 2'd1,
        BUS_SEL_2   = 2'd2,
        BUS_SEL_REG = 2'd3
    } bus_sel_t;

    ////////////////////////////////////////
    // structs
    ////////////////////////////////////////

    // one source operand as seen by the RS
    typedef struct packed {
        logic                  needed;
        logic                  ready;
        logic [`ALU_TAG_W-1:0] tag;
    } source_status_t;

    // dispatched task
    typedef struct packed {
        alu_op_t               op;
        logic                  itype;
        source_status_t        source_0;
        source_status_t        source_1;
        logic [`ALU_TAG_W-1:0] dest_tag;
        logic [`ALU_IMM_W-1:0] imm16;
        logic [`ALU_ROB_W-1:0] rob_index;
    } alu_task_t;

    // one incoming complete bus, data trails tag by a cycle
    typedef struct packed {
        logic                   tag_valid;
        logic [`ALU_TAG_W-1:0]  tag;
        logic [`ALU_WORD_W-1:0] data;
    } complete_bus_t;

    // this pipeline's own complete bus
    typedef struct packed {
        logic                   tag_valid;
        logic [`ALU_TAG_W-1:0]  tag;
        logic [`ALU_ROB_W-1:0]  rob_index;
        logic                   data_valid;
        logic [`ALU_WORD_W-1:0] data;
    } result_bus_t;

    // register file read request
    typedef struct packed {
        logic                  valid;
        logic [`ALU_TAG_W-1:0] tag_0;
        logic [`ALU_TAG_W-1:0] tag_1;
    } rf_read_req_t;

    // RS -> EX latch contents
    typedef struct packed {
        logic                   valid;
        alu_op_t                op;
        logic [`ALU_WORD_W-1:0] operand_0;
        logic [`ALU_WORD_W-1:0] operand_1;
        bus_sel_t               sel_0;
        bus_sel_t               sel_1;
        logic [`ALU_TAG_W-1:0]  dest_tag;
        logic [`ALU_ROB_W-1:0]  rob_index;
    } ex_task_t;

    // tag match result for one source
    typedef struct packed {
        logic     match;
        bus_sel_t sel;
    } operand_res_t;

endpackage

`default_nettype wire

// File: operand_match.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

// combinational wakeup check of one RS source against the complete buses
module operand_match (
    input  wire alu_pkg::source_status_t source,
    input  wire alu_pkg::complete_bus_t  buses [`ALU_NUM_BUSES],
    output alu_pkg::operand_res_t        res
);

    ////////////////////////////////////////
    // per bus valid tag match
    ////////////////////////////////////////

    logic [`ALU_NUM_BUSES-1:0] hit;

    always_comb begin
        for (int i = 0; i < `ALU_NUM_BUSES; i++) begin
            // tag only counts while its bus marks it valid
            hit[i] = buses[i].tag_valid && (buses[i].tag == source.tag);
        end
    end

    ////////////////////////////////////////
    // priority encode, lowest bus wins
    ////////////////////////////////////////

    always_comb begin
        // nothing matched
        // operand stays on the register value
        res.match = |hit;
        res.sel   = alu_pkg::BUS_SEL_REG;

        // walk down so the lowest hit is written last
        for (int i = `ALU_NUM_BUSES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                res.sel = alu_pkg::bus_sel_t'(i[1:0]);
            end
        end
    end

endmodule

`default_nettype wire

// File: rs_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

// single entry reservation station plus the RS -> EX latch
module rs_stage (
    input  wire logic                    CLK,
    input  wire logic                    nRST,
    // dispatch side
    input  wire logic                    dispatch_valid,
    input  wire alu_pkg::alu_task_t      dispatch_task,
    output logic                         rs_full,
    // kill bus
    input  wire logic                    kill_valid,
    input  wire logic [`ALU_ROB_W-1:0]   kill_rob_index,
    // complete buses, tag half only used here
    input  wire alu_pkg::complete_bus_t  buses [`ALU_NUM_BUSES],
    // register file read port
    output alu_pkg::rf_read_req_t        rf_req,
    input  wire logic                    rf_serviced,
    input  wire logic [`ALU_WORD_W-1:0]  rf_data_0,
    input  wire logic [`ALU_WORD_W-1:0]  rf_data_1,
    // to EX
    output alu_pkg::ex_task_t            ex_task
);

    // RS entry
    logic               rs_valid;
    logic               next_rs_valid;
    alu_pkg::alu_task_t rs_task;
    alu_pkg::alu_task_t next_rs_task;

    // EX latch
    alu_pkg::ex_task_t  ex_payload;
    alu_pkg::ex_task_t  next_ex;

    // wakeup results
    alu_pkg::operand_res_t res_0;
    alu_pkg::operand_res_t res_1;

    logic [`ALU_WORD_W-1:0] imm32;

    // issue decision terms
    logic kill_hit;
    logic have_0;
    logic have_1;
    logic bypass_0;
    logic bypass_1;
    logic need_rf;
    logic can_go;
    logic issue;

    operand_match u_match_0 (
        .source (rs_task.source_0),
        .buses  (buses),
        .res    (res_0)
    );

    operand_match u_match_1 (
        .source (rs_task.source_1),
        .buses  (buses),
        .res    (res_1)
    );

    ////////////////////////////////////////
    // immediate extension
    ////////////////////////////////////////

    always_comb begin
        case (rs_task.op)
            // signed arithmetic sign extends
            alu_pkg::ALU_ADD, alu_pkg::ALU_SUB, alu_pkg::ALU_SLT: begin
                imm32 = {{(`ALU_WORD_W - `ALU_IMM_W){rs_task.imm16[`ALU_IMM_W-1]}},
                         rs_task.imm16};
            end
            // logic ops, shifts, lui, link
            default: begin
                imm32 = {{(`ALU_WORD_W - `ALU_IMM_W){1'b0}}, rs_task.imm16};
            end
        endcase
    end

    ////////////////////////////////////////
    // issue / wait / kill
    ////////////////////////////////////////

    always_comb begin
        // kill only bites while the task sits here
        kill_hit = kill_valid && rs_valid && (rs_task.rob_index == kill_rob_index);

        // a ready source reads the RF, else a bus hit bypasses
        bypass_0 = rs_task.source_0.needed && !rs_task.source_0.ready && res_0.match;
        bypass_1 = rs_task.source_1.needed && !rs_task.source_1.ready && res_1.match;
        have_0   = !rs_task.source_0.needed || rs_task.source_0.ready || res_0.match;
        have_1   = !rs_task.source_1.needed || rs_task.source_1.ready || res_1.match;

        // RF port only when some needed source lives there
        need_rf  = (rs_task.source_0.needed && rs_task.source_0.ready)
                || (rs_task.source_1.needed && rs_task.source_1.ready);

        can_go   = rs_valid && !kill_hit && have_0 && have_1;
        issue    = can_go && (!need_rf || rf_serviced);

        // held task that cannot leave this cycle
        rs_full  = rs_valid && !kill_hit && !issue;

        rf_req.valid = can_go && need_rf;
        rf_req.tag_0 = rs_task.source_0.tag;
        rf_req.tag_1 = rs_task.source_1.tag;
    end

    ////////////////////////////////////////
    // next RS entry
    ////////////////////////////////////////

    always_comb begin
        next_rs_valid = rs_valid;
        next_rs_task  = rs_task;

        if (kill_hit || issue) begin
            next_rs_valid = 1'b0;
        end else if (rs_valid) begin
            // still waiting, remember any wakeup seen now
            if (rs_task.source_0.needed && res_0.match) begin
                next_rs_task.source_0.ready = 1'b1;
            end
            if (rs_task.source_1.needed && res_1.match) begin
                next_rs_task.source_1.ready = 1'b1;
            end
        end

        // new task may land in the issue cycle
        if (dispatch_valid) begin
            next_rs_valid = 1'b1;
            next_rs_task  = dispatch_task;
        end
    end

    ////////////////////////////////////////
    // next EX latch
    ////////////////////////////////////////

    always_comb begin
        next_ex.valid     = issue;
        next_ex.op        = rs_task.op;
        next_ex.dest_tag  = rs_task.dest_tag;
        next_ex.rob_index = rs_task.rob_index;

        // unused sources carry the immediate
        next_ex.operand_0 = rs_task.source_0.needed ? rf_data_0 : imm32;
        next_ex.operand_1 = rs_task.source_1.needed ? rf_data_1 : imm32;

        // bypassed operands grab bus data in EX
        next_ex.sel_0 = bypass_0 ? res_0.sel : alu_pkg::BUS_SEL_REG;
        next_ex.sel_1 = bypass_1 ? res_1.sel : alu_pkg::BUS_SEL_REG;
    end

    // control state and EX latch
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rs_valid   <= 1'b0;
            ex_payload <= '0;
        end else begin
            rs_valid   <= next_rs_valid;
            ex_payload <= next_ex;
        end
    end

    // payload
    always_ff @(posedge CLK) begin
        rs_task <= next_rs_task;
    end

    always_comb begin
        ex_task = ex_payload;
    end

endmodule

`default_nettype wire

// File: alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

// EX and data broadcast stages
module alu_exec (
    input  wire logic                   CLK,
    input  wire logic                   nRST,
    input  wire alu_pkg::ex_task_t      ex_task,
    // data half of the complete buses
    input  wire logic [`ALU_WORD_W-1:0] bus_data [`ALU_NUM_BUSES],
    output alu_pkg::result_bus_t        result
);

    localparam int HALF_W = `ALU_WORD_W / 2;

    logic [`ALU_WORD_W-1:0] op_a;
    logic [`ALU_WORD_W-1:0] op_b;
    logic [`ALU_WORD_W-1:0] alu_out;

    // data stage
    logic                   data_valid;
    logic [`ALU_WORD_W-1:0] data_q;

    ////////////////////////////////////////
    // bypass muxes
    ////////////////////////////////////////

    // bus data arrives the cycle after its tag, i.e. now
    function automatic logic [`ALU_WORD_W-1:0] pick(
        input alu_pkg::bus_sel_t      sel,
        input logic [`ALU_WORD_W-1:0] captured
    );
        logic [`ALU_WORD_W-1:0] val;
        case (sel)
            alu_pkg::BUS_SEL_0: val = bus_data[0];
            alu_pkg::BUS_SEL_1: val = bus_data[1];
            alu_pkg::BUS_SEL_2: val = bus_data[2];
            default:            val = captured;
        endcase
        return val;
    endfunction

    always_comb begin
        op_a = pick(ex_task.sel_0, ex_task.operand_0);
        op_b = pick(ex_task.sel_1, ex_task.operand_1);
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (ex_task.op)
            alu_pkg::ALU_ADD:  alu_out = op_a + op_b;
            alu_pkg::ALU_SUB:  alu_out = op_a - op_b;
            alu_pkg::ALU_AND:  alu_out = op_a & op_b;
            alu_pkg::ALU_OR:   alu_out = op_a | op_b;
            alu_pkg::ALU_NOR:  alu_out = ~(op_a | op_b);
            alu_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            // compares give 1 or 0
            alu_pkg::ALU_SLT:  alu_out = {{(`ALU_WORD_W-1){1'b0}},
                                          $signed(op_a) < $signed(op_b)};
            alu_pkg::ALU_SLTU: alu_out = {{(`ALU_WORD_W-1){1'b0}}, op_a < op_b};
            // shift amount comes from operand 0
            alu_pkg::ALU_SLLV: alu_out = op_b << op_a[`ALU_SHAMT_W-1:0];
            alu_pkg::ALU_SRLV: alu_out = op_b >> op_a[`ALU_SHAMT_W-1:0];
            alu_pkg::ALU_LUI:  alu_out = {op_b[HALF_W-1:0], {HALF_W{1'b0}}};
            // return address, word aligned pc + 4
            alu_pkg::ALU_LINK: alu_out = {{HALF_W{1'b0}},
                                          op_b[HALF_W-1:2] + {{(HALF_W-3){1'b0}}, 1'b1},
                                          2'b00};
            default:           alu_out = op_a + op_b;
        endcase
    end

    ////////////////////////////////////////
    // data stage register
    ////////////////////////////////////////

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= ex_task.valid;
        end
    end

    always_ff @(posedge CLK) begin
        data_q <= alu_out;
    end

    // tag half from EX, data half one cycle later
    always_comb begin
        result.tag_valid  = ex_task.valid;
        result.tag        = ex_task.dest_tag;
        result.rob_index  = ex_task.rob_index;
        result.data_valid = data_valid;
        result.data       = data_q;
    end

endmodule

`default_nettype wire

// File: alu_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

// ALU pipeline top: dispatch latch and RS, then EX and data broadcast
module alu_pipeline (
    input  wire logic                   CLK,
    input  wire logic                   nRST,
    // dispatch
    input  wire logic                   dispatch_valid,
    input  wire alu_pkg::alu_task_t     dispatch_task,
    output logic                        rs_full,
    // kill bus
    input  wire logic                   kill_valid,
    input  wire logic [`ALU_ROB_W-1:0]  kill_rob_index,
    // incoming complete buses
    input  wire alu_pkg::complete_bus_t buses [`ALU_NUM_BUSES],
    // register file
    output alu_pkg::rf_read_req_t       rf_req,
    input  wire logic                   rf_serviced,
    input  wire logic [`ALU_WORD_W-1:0] rf_data_0,
    input  wire logic [`ALU_WORD_W-1:0] rf_data_1,
    // own complete bus
    output alu_pkg::result_bus_t        result
);

    // RS -> EX
    alu_pkg::ex_task_t ex_task;

    // bus data for the EX bypass
    logic [`ALU_WORD_W-1:0] bus_data [`ALU_NUM_BUSES];

    for (genvar i = 0; i < `ALU_NUM_BUSES; i++) begin : g_bus_data
        assign bus_data[i] = buses[i].data;
    end

    ////////////////////////////////////////
    // stages
    ////////////////////////////////////////

    rs_stage u_rs (
        .CLK            (CLK),
        .nRST           (nRST),
        .dispatch_valid (dispatch_valid),
        .dispatch_task  (dispatch_task),
        .rs_full        (rs_full),
        .kill_valid     (kill_valid),
        .kill_rob_index (kill_rob_index),
        .buses          (buses),
        .rf_req         (rf_req),
        .rf_serviced    (rf_serviced),
        .rf_data_0      (rf_data_0),
        .rf_data_1      (rf_data_1),
        .ex_task        (ex_task)
    );

    alu_exec u_exec (
        .CLK      (CLK),
        .nRST     (nRST),
        .ex_task  (ex_task),
        .bus_data (bus_data),
        .result   (result)
    );

endmodule

`default_nettype wire

// File: tb_alu_model.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

////////////////////////////////////////
// reference model of the ALU pipeline
////////////////////////////////////////

// one ALU op, operand a is source 0 and b is source 1
function automatic logic [`ALU_WORD_W-1:0] model_alu(
    input alu_pkg::alu_op_t       op,
    input logic [`ALU_WORD_W-1:0] a,
    input logic [`ALU_WORD_W-1:0] b
);
    logic [`ALU_WORD_W-1:0] r;
    logic [13:0]            ret_word;
    // return address is word index plus one
    ret_word = b[15:2] + 14'd1;
    case (op)
        alu_pkg::ALU_ADD:  r = a + b;
        alu_pkg::ALU_SUB:  r = a - b;
        alu_pkg::ALU_AND:  r = a & b;
        alu_pkg::ALU_OR:   r = a | b;
        alu_pkg::ALU_NOR:  r = ~(a | b);
        alu_pkg::ALU_XOR:  r = a ^ b;
        alu_pkg::ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_pkg::ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
        alu_pkg::ALU_SLLV: r = b << a[4:0];
        alu_pkg::ALU_SRLV: r = b >> a[4:0];
        alu_pkg::ALU_LUI:  r = {b[15:0], 16'h0000};
        alu_pkg::ALU_LINK: r = {16'h0000, ret_word, 2'b00};
        default:           r = '0;
    endcase
    return r;
endfunction

// signed arithmetic sign extends, everything else zero extends
function automatic logic [`ALU_WORD_W-1:0] model_ext_imm(
    input alu_pkg::alu_op_t      op,
    input logic [`ALU_IMM_W-1:0] imm
);
    logic sign_ext;
    sign_ext = (op == alu_pkg::ALU_ADD) || (op == alu_pkg::ALU_SUB)
            || (op == alu_pkg::ALU_SLT);
    return sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};
endfunction

// lowest bus carrying this tag, -1 if none
function automatic int model_wake_bus(
    input logic [`ALU_TAG_W-1:0] tag,
    input alu_pkg::complete_bus_t bus [`ALU_NUM_BUSES]
);
    int hit;
    hit = -1;
    for (int i = 0; i < `ALU_NUM_BUSES; i++) begin
        if (hit < 0 && bus[i].tag_valid && bus[i].tag == tag) begin
            hit = i;
        end
    end
    return hit;
endfunction

`endif

// File: tb_alu_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module tb_alu_pipeline;

    localparam int NUM_TASKS       = 400;
    localparam int CYCLES_PER_TASK = 64;
    localparam int CLK_NS          = 10;

    typedef logic [`ALU_TAG_W-1:0] tag_t;
    typedef logic [`ALU_ROB_W-1:0] rob_t;
    typedef logic [`ALU_IMM_W-1:0] imm_t;

    logic                   CLK;
    logic                   nRST;
    logic                   dispatch_valid;
    alu_pkg::alu_task_t     dispatch_task;
    logic                   rs_full;
    logic                   kill_valid;
    rob_t                   kill_rob_index;
    alu_pkg::complete_bus_t buses [`ALU_NUM_BUSES];
    alu_pkg::rf_read_req_t  rf_req;
    logic                   rf_serviced;
    logic [`ALU_WORD_W-1:0] rf_data_0;
    logic [`ALU_WORD_W-1:0] rf_data_1;
    alu_pkg::result_bus_t   result;

    // register file and the data each bus sends after its tag
    logic [`ALU_WORD_W-1:0] rf_mem [2**`ALU_TAG_W];
    logic [`ALU_WORD_W-1:0] bus_next [`ALU_NUM_BUSES];

    // model of the RS entry and of the two stages after it
    alu_pkg::alu_task_t   m_task;
    logic                 m_valid;
    logic                 issued_last;
    logic                 tagged_last;
    alu_pkg::result_bus_t expect_q [$];
    int                   dispatched;
    int                   seen;
    int                   killed;

    `include "tb_alu_model.svh"

    alu_pipeline dut (
        .CLK            (CLK),
        .nRST           (nRST),
        .dispatch_valid (dispatch_valid),
        .dispatch_task  (dispatch_task),
        .rs_full        (rs_full),
        .kill_valid     (kill_valid),
        .kill_rob_index (kill_rob_index),
        .buses          (buses),
        .rf_req         (rf_req),
        .rf_serviced    (rf_serviced),
        .rf_data_0      (rf_data_0),
        .rf_data_1      (rf_data_1),
        .result         (result)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_NS / 2) CLK = ~CLK;
    end

    // run limit grows with the number of tasks
    initial begin
        #((NUM_TASKS * CYCLES_PER_TASK + 20) * CLK_NS);
        fail_run("timeout, the run did not finish in time");
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
        end
    endtask

    // tags only matter while the request is valid
    task automatic compare_rf_req(input string name, input alu_pkg::rf_read_req_t exp,
                                  input alu_pkg::rf_read_req_t act);
        if (act.valid !== exp.valid
                || (exp.valid && {act.tag_0, act.tag_1} !== {exp.tag_0, exp.tag_1})) begin
            fail_run($sformatf("MISMATCH %s expected %b/%h/%h actual %b/%h/%h", name,
                               exp.valid, exp.tag_0, exp.tag_1,
                               act.valid, act.tag_0, act.tag_1));
        end
    endtask

    task automatic compare_result_tag(input string name, input alu_pkg::result_bus_t exp,
                                      input alu_pkg::result_bus_t act);
        if ({act.tag, act.rob_index} !== {exp.tag, exp.rob_index}) begin
            fail_run($sformatf("MISMATCH %s expected tag %h rob %h actual tag %h rob %h",
                               name, exp.tag, exp.rob_index, act.tag, act.rob_index));
        end
    endtask

    task automatic compare_result_data(input string name, input alu_pkg::result_bus_t exp,
                                       input alu_pkg::result_bus_t act);
        if (act.data !== exp.data) begin
            fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp.data, act.data));
        end
    endtask

    // data of the task tagged last cycle, then the tag of the task issued last cycle
    task automatic check_result_bus();
        alu_pkg::result_bus_t exp;
        compare_bit("data_valid", tagged_last, result.data_valid);
        if (result.data_valid) begin
            exp = expect_q.pop_front();
            compare_result_data($sformatf("result data, result %0d", seen), exp, result);
            seen++;
        end
        compare_bit("tag_valid", issued_last, result.tag_valid);
        if (result.tag_valid) begin
            compare_result_tag($sformatf("result tag, result %0d", seen), expect_q[0], result);
        end
        tagged_last = issued_last;
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    // legal task only, never source 1 alone
    function automatic alu_pkg::alu_task_t random_task();
        alu_pkg::alu_task_t t;
        t.op              = alu_pkg::alu_op_t'(4'($urandom % 12));
        t.itype           = ($urandom % 3) == 0;
        t.source_0.needed = 1'b1;
        t.source_0.ready  = ($urandom % 2) == 0;
        t.source_0.tag    = tag_t'($urandom);
        t.source_1.needed = !t.itype;
        t.source_1.ready  = ($urandom % 2) == 0;
        t.source_1.tag    = tag_t'($urandom);
        // lui and link read only the immediate
        if (t.op == alu_pkg::ALU_LUI || t.op == alu_pkg::ALU_LINK) begin
            t.itype           = 1'b1;
            t.source_0.needed = 1'b0;
            t.source_1.needed = 1'b0;
        end
        t.dest_tag  = tag_t'($urandom);
        t.imm16     = imm_t'($urandom);
        t.rob_index = rob_t'($urandom);
        return t;
    endfunction

    // tags lean toward what the RS waits for
    task automatic drive_buses();
        for (int i = 0; i < `ALU_NUM_BUSES; i++) begin
            buses[i].data      = bus_next[i];
            bus_next[i]        = $urandom;
            buses[i].tag_valid = ($urandom % 2) == 0;
            if (m_valid && ($urandom % 2) == 0) begin
                buses[i].tag = (($urandom % 2) == 0) ? m_task.source_0.tag
                                                     : m_task.source_1.tag;
            end else begin
                buses[i].tag = tag_t'($urandom);
            end
        end
    endtask

    // one clock cycle: drive on the falling edge, check once settled
    task automatic step(input logic offer);
        alu_pkg::source_status_t src [2];
        logic [`ALU_WORD_W-1:0]  opnd [2];
        int                      wake [2];
        alu_pkg::rf_read_req_t   exp_req;
        alu_pkg::result_bus_t    exp_res;
        logic                    kill_hit;
        logic                    need_rf;
        logic                    can_go;
        logic                    issue;
        logic                    exp_full;

        @(negedge CLK);
        drive_buses();
        kill_valid     = ($urandom % 8) == 0;
        kill_rob_index = (m_valid && ($urandom % 2) == 0) ? m_task.rob_index : rob_t'($urandom);
        rf_serviced    = ($urandom % 4) != 0;
        rf_data_0      = rf_mem[m_task.source_0.tag];
        rf_data_1      = rf_mem[m_task.source_1.tag];

        // resolve both sources of the held task
        src[0]   = m_task.source_0;
        src[1]   = m_task.source_1;
        kill_hit = m_valid && kill_valid && (kill_rob_index == m_task.rob_index);
        need_rf  = 1'b0;
        can_go   = m_valid && !kill_hit;
        for (int s = 0; s < 2; s++) begin
            opnd[s] = '0;
            wake[s] = model_wake_bus(src[s].tag, buses);
            if (!src[s].needed) begin
                opnd[s] = model_ext_imm(m_task.op, m_task.imm16);
            end else if (src[s].ready) begin
                opnd[s] = rf_mem[src[s].tag];
                need_rf = 1'b1;
            end else if (wake[s] >= 0) begin
                opnd[s] = bus_next[wake[s]];
            end else begin
                can_go = 1'b0;
            end
        end
        issue         = can_go && (!need_rf || rf_serviced);
        exp_full      = m_valid && !kill_hit && !issue;
        exp_req.valid = can_go && need_rf;
        exp_req.tag_0 = src[0].tag;
        exp_req.tag_1 = src[1].tag;

        // dispatch only into a free RS
        dispatch_valid = offer && !exp_full && (($urandom % 4) != 0);
        if (dispatch_valid) begin
            dispatch_task = random_task();
            dispatched++;
        end

        #1;
        compare_bit("rs_full", exp_full, rs_full);
        compare_rf_req("rf read request", exp_req, rf_req);
        check_result_bus();
        if (issue) begin
            exp_res            = '0;
            exp_res.tag_valid  = 1'b1;
            exp_res.tag        = m_task.dest_tag;
            exp_res.rob_index  = m_task.rob_index;
            exp_res.data_valid = 1'b1;
            exp_res.data       = model_alu(m_task.op, opnd[0], opnd[1]);
            expect_q.push_back(exp_res);
        end
        issued_last = issue;

        // next RS state, waiting task remembers its wakeups
        if (kill_hit) begin
            killed++;
        end
        if (kill_hit || issue) begin
            m_valid = 1'b0;
        end else if (m_valid) begin
            if (src[0].needed && wake[0] >= 0) begin
                m_task.source_0.ready = 1'b1;
            end
            if (src[1].needed && wake[1] >= 0) begin
                m_task.source_1.ready = 1'b1;
            end
        end
        if (dispatch_valid) begin
            m_valid = 1'b1;
            m_task  = dispatch_task;
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'h2473));
        nRST           = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_task  = '0;
        kill_valid     = 1'b0;
        kill_rob_index = '0;
        rf_serviced    = 1'b0;
        rf_data_0      = '0;
        rf_data_1      = '0;
        for (int i = 0; i < `ALU_NUM_BUSES; i++) begin
            buses[i]    = '0;
            bus_next[i] = $urandom;
        end
        for (int i = 0; i < 2**`ALU_TAG_W; i++) begin
            rf_mem[i] = $urandom;
        end
        m_task      = '0;
        m_valid     = 1'b0;
        issued_last = 1'b0;
        tagged_last = 1'b0;
        dispatched  = 0;
        seen        = 0;
        killed      = 0;

        repeat (10) @(posedge CLK);
        @(negedge CLK);
        // everything quiet out of reset
        compare_bit("reset rs_full", 1'b0, rs_full);
        compare_bit("reset rf request valid", 1'b0, rf_req.valid);
        compare_bit("reset tag_valid", 1'b0, result.tag_valid);
        compare_bit("reset data_valid", 1'b0, result.data_valid);
        nRST = 1'b1;

        while (dispatched < NUM_TASKS || m_valid || expect_q.size() != 0) begin
            step(dispatched < NUM_TASKS);
        end
        // idle cycles, nothing more may show up
        repeat (4) step(1'b0);

        if (seen + killed != NUM_TASKS) begin
            fail_run($sformatf("only %0d of %0d tasks completed or were killed",
                               seen + killed, NUM_TASKS));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
alu_pkg.sv
operand_match.sv
rs_stage.sv
alu_exec.sv
alu_pipeline.sv
tb_alu_pipeline.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timescale 1ns/1ps --top-module tb_alu_pipeline -f sources.f &&
./obj_dir/Vtb_alu_pipeline || exit 1
